// File: Bender.yml
package:
  name: alu_registers

sources:
  - logic/constants_pkg.sv
  - logic/alu.sv
  - logic/register_file.sv
  - logic/op_sequencer.sv
  - logic/alu_registers.sv
  - target: test
    files:
      - tb/alu_registers_tb.sv

// File: alu_registers.f
logic/constants_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/op_sequencer.sv
logic/alu_registers.sv
tb/alu_registers_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int DATA_WIDTH = constants_pkg::DEFAULT_DATA_WIDTH
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  logic                  subtract,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  cout,
    output logic                  ovf
);

    import constants_pkg::*;

    localparam int MSB = DATA_WIDTH - 1;

    // Second operand after optional inversion
    logic [DATA_WIDTH-1:0] b_eff;

    // Sum with one extra bit for the carry out
    logic [DATA_WIDTH:0] sum;

    ////////////////////////////////////////////////////////////
    // Add or subtract
    ////////////////////////////////////////////////////////////

    // Subtraction as a + ~b + 1
    assign b_eff = subtract ? ~b : b;

    assign sum = {1'b0, a} + {1'b0, b_eff} + {{DATA_WIDTH{1'b0}}, subtract};

    assign result = sum[MSB:0];

    // High on subtract means no borrow, i.e. a >= b unsigned
    assign cout = sum[DATA_WIDTH];

    ////////////////////////////////////////////////////////////
    // Signed overflow
    ////////////////////////////////////////////////////////////

    // Operands of equal sign giving a result of the other sign
    assign ovf = (a[MSB] == b_eff[MSB]) && (result[MSB] != a[MSB]);

endmodule

// File: logic/alu_registers.sv
`timescale 1ns/1ps

module alu_registers #(
    parameter int DATA_WIDTH = constants_pkg::DEFAULT_DATA_WIDTH,
    parameter int ADDR_WIDTH = constants_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  constants_pkg::ALUOp   op,
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic [ADDR_WIDTH-1:0] addr_b,
    input  logic [ADDR_WIDTH-1:0] addr_r,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  data_valid,
    output logic                  carry,
    output logic                  overflow
);

    import constants_pkg::*;

    // Register file ports
    logic [ADDR_WIDTH-1:0] rd0_addr;
    logic [ADDR_WIDTH-1:0] rd1_addr;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic                  wr_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [DATA_WIDTH-1:0] rd0_data;
    logic [DATA_WIDTH-1:0] rd1_data;

    // ALU control and results
    logic                  subtract;
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  alu_cout;
    logic                  alu_ovf;

    ////////////////////////////////////////////////////////////
    // Command stage and write-back
    ////////////////////////////////////////////////////////////

    op_sequencer #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) sequencer (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .op         (op),
        .addr_a     (addr_a),
        .addr_b     (addr_b),
        .addr_r     (addr_r),
        .data_in    (data_in),
        .rd0_data   (rd0_data),
        .alu_result (alu_result),
        .alu_cout   (alu_cout),
        .alu_ovf    (alu_ovf),
        .rd0_addr   (rd0_addr),
        .rd1_addr   (rd1_addr),
        .wr_addr    (wr_addr),
        .wr_en      (wr_en),
        .subtract   (subtract),
        .wr_data    (wr_data),
        .data_out   (data_out),
        .data_valid (data_valid),
        .carry      (carry),
        .overflow   (overflow)
    );

    ////////////////////////////////////////////////////////////
    // Storage and arithmetic
    ////////////////////////////////////////////////////////////

    register_file #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) registers (
        .clk      (clk),
        .reset    (reset),
        .rd0_addr (rd0_addr),
        .rd1_addr (rd1_addr),
        .wr_addr  (wr_addr),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd0_data (rd0_data),
        .rd1_data (rd1_data)
    );

    // Operands straight from the read ports
    alu #(
        .DATA_WIDTH (DATA_WIDTH)
    ) arith_unit (
        .a        (rd0_data),
        .b        (rd1_data),
        .subtract (subtract),
        .result   (alu_result),
        .cout     (alu_cout),
        .ovf      (alu_ovf)
    );

endmodule

// File: logic/constants_pkg.sv
package constants_pkg;

    ////////////////////////////////////////////////////////////
    // Command encoding
    ////////////////////////////////////////////////////////////

    // Two-bit command code seen on the op port
    typedef enum logic [1:0] {
        REG_READ  = 2'b00,
        REG_WRITE = 2'b01,
        ADD       = 2'b10,
        SUB       = 2'b11
    } ALUOp;

    ////////////////////////////////////////////////////////////
    // Default datapath sizes
    ////////////////////////////////////////////////////////////

    // One byte per register
    localparam int DEFAULT_DATA_WIDTH = 8;

    // Eight registers
    localparam int DEFAULT_ADDR_WIDTH = 3;

endpackage

// File: logic/op_sequencer.sv
`timescale 1ns/1ps

module op_sequencer #(
    parameter int DATA_WIDTH = constants_pkg::DEFAULT_DATA_WIDTH,
    parameter int ADDR_WIDTH = constants_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  constants_pkg::ALUOp   op,
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic [ADDR_WIDTH-1:0] addr_b,
    input  logic [ADDR_WIDTH-1:0] addr_r,
    input  logic [DATA_WIDTH-1:0] data_in,
    input  logic [DATA_WIDTH-1:0] rd0_data,
    input  logic [DATA_WIDTH-1:0] alu_result,
    input  logic                  alu_cout,
    input  logic                  alu_ovf,
    output logic [ADDR_WIDTH-1:0] rd0_addr,
    output logic [ADDR_WIDTH-1:0] rd1_addr,
    output logic [ADDR_WIDTH-1:0] wr_addr,
    output logic                  wr_en,
    output logic                  subtract,
    output logic [DATA_WIDTH-1:0] wr_data,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic                  data_valid,
    output logic                  carry,
    output logic                  overflow
);

    import constants_pkg::*;

    // Command stage
    logic                  stage_valid;
    ALUOp                  stage_op;
    logic [ADDR_WIDTH-1:0] stage_addr_a;
    logic [ADDR_WIDTH-1:0] stage_addr_b;
    logic [ADDR_WIDTH-1:0] stage_addr_r;
    logic [DATA_WIDTH-1:0] stage_data;

    // Decoded from the stage
    logic stage_arith;
    logic stage_reports;

    ////////////////////////////////////////////////////////////
    // Command capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else begin
            stage_valid <= cmd_valid;
        end
    end

    // Payload only matters while stage_valid is set
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            stage_op     <= op;
            stage_addr_a <= addr_a;
            stage_addr_b <= addr_b;
            stage_addr_r <= addr_r;
            stage_data   <= data_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // Operand routing and write-back
    ////////////////////////////////////////////////////////////

    assign stage_arith   = (stage_op == ADD) || (stage_op == SUB);
    assign stage_reports = stage_valid && (stage_op != REG_WRITE);

    // A on port 0, B on port 1
    assign rd0_addr = stage_addr_a;
    assign rd1_addr = stage_addr_b;
    assign subtract = (stage_op == SUB);

    // Every command except REG_READ writes a register
    assign wr_en   = stage_valid && (stage_op != REG_READ);
    assign wr_addr = (stage_op == REG_WRITE) ? stage_addr_a : stage_addr_r;
    assign wr_data = (stage_op == REG_WRITE) ? stage_data : alu_result;

    ////////////////////////////////////////////////////////////
    // Result and flag registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            data_valid <= 1'b0;
            carry      <= 1'b0;
            overflow   <= 1'b0;
        end else begin
            data_valid <= stage_reports;
            // Flags hold through reads and writes
            if (stage_valid && stage_arith) begin
                carry    <= alu_cout;
                overflow <= alu_ovf;
            end
        end
    end

    // Old register contents for a read, else the ALU result
    always_ff @(posedge clk) begin
        if (stage_reports) begin
            data_out <= (stage_op == REG_READ) ? rd0_data : alu_result;
        end
    end

    // Checks

    op_known_check: assert property (
        @(posedge clk) disable iff (reset)
        cmd_valid |-> !$isunknown(op)
    ) else $error("op_sequencer: unknown op with cmd_valid");

    // Two edges from strobe to data_valid
    valid_source_check: assert property (
        @(posedge clk) disable iff (reset)
        data_valid |-> $past(cmd_valid && op != REG_WRITE, 2)
    ) else $error("op_sequencer: data_valid without a reporting command");

    flag_hold_check: assert property (
        @(posedge clk) disable iff (reset)
        (!$stable(carry) || !$stable(overflow)) && !$past(reset)
            |-> $past(cmd_valid && (op == ADD || op == SUB), 2)
    ) else $error("op_sequencer: flags changed without ADD or SUB");

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file #(
    parameter int DATA_WIDTH = constants_pkg::DEFAULT_DATA_WIDTH,
    parameter int ADDR_WIDTH = constants_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] rd0_addr,
    input  logic [ADDR_WIDTH-1:0] rd1_addr,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic [DATA_WIDTH-1:0] rd0_data,
    output logic [DATA_WIDTH-1:0] rd1_data
);

    import constants_pkg::*;

    localparam int NUM_REGS = 2 ** ADDR_WIDTH;

    // Register storage
    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    // Reset clears every register so reads after reset return zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Contents before the write of the coming edge
    assign rd0_data = regs[rd0_addr];
    assign rd1_data = regs[rd1_addr];

    // Checks

    // A write must carry a known address and value into the array
    wr_known_check: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown({wr_addr, wr_data})
    ) else $error("register_file write with unknown address or data");

endmodule

// File: tb/alu_registers_tb.sv
`timescale 1ns/1ps

module alu_registers_tb;

    import constants_pkg::*;

    localparam int DATA_WIDTH = constants_pkg::DEFAULT_DATA_WIDTH;
    localparam int ADDR_WIDTH = constants_pkg::DEFAULT_ADDR_WIDTH;
    localparam int NUM_REGS   = 2 ** ADDR_WIDTH;
    localparam int SIGNED_MAX = 2 ** (DATA_WIDTH - 1) - 1;
    localparam int SIGNED_MIN = -(2 ** (DATA_WIDTH - 1));

    // Command counts per test
    localparam int ADD_COUNT  = 200;
    localparam int SUB_COUNT  = 200;
    localparam int CHAIN_COUNT = 150;
    localparam int HOLD_COUNT = 30;

    // Roughly three times the ~700 cycles of reset, commands and drains
    localparam int MAX_CYCLES = 2000;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  cmd_valid;
    ALUOp                  op;
    logic [ADDR_WIDTH-1:0] addr_a;
    logic [ADDR_WIDTH-1:0] addr_b;
    logic [ADDR_WIDTH-1:0] addr_r;
    logic [DATA_WIDTH-1:0] data_in;
    logic [DATA_WIDTH-1:0] data_out;
    logic                  data_valid;
    logic                  carry;
    logic                  overflow;

    // Reference model state
    logic [DATA_WIDTH-1:0] model_regs [NUM_REGS];
    logic                  model_carry;
    logic                  model_ovf;

    // Expected response, launched with the command and delayed two edges
    logic                  exp_valid = 1'b0;
    logic [DATA_WIDTH-1:0] exp_data = '0;
    logic                  exp_carry = 1'b0;
    logic                  exp_ovf = 1'b0;
    logic                  exp_valid_d1 = 1'b0;
    logic [DATA_WIDTH-1:0] exp_data_d1 = '0;
    logic                  exp_carry_d1 = 1'b0;
    logic                  exp_ovf_d1 = 1'b0;
    logic                  exp_valid_d2 = 1'b0;
    logic [DATA_WIDTH-1:0] exp_data_d2 = '0;
    logic                  exp_carry_d2 = 1'b0;
    logic                  exp_ovf_d2 = 1'b0;

    int error_count = 0;
    int cycle_count = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int test_index = 0;
    int errors_at_start = 0;

    alu_registers #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .op         (op),
        .addr_a     (addr_a),
        .addr_b     (addr_b),
        .addr_r     (addr_r),
        .data_in    (data_in),
        .data_out   (data_out),
        .data_valid (data_valid),
        .carry      (carry),
        .overflow   (overflow)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        exp_valid_d1 <= exp_valid;
        exp_data_d1  <= exp_data;
        exp_carry_d1 <= exp_carry;
        exp_ovf_d1   <= exp_ovf;
        exp_valid_d2 <= exp_valid_d1;
        exp_data_d2  <= exp_data_d1;
        exp_carry_d2 <= exp_carry_d1;
        exp_ovf_d2   <= exp_ovf_d1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response checks, two edges after each strobe
    ////////////////////////////////////////////////////////////

    valid_check: assert property (
        @(posedge clk) disable iff (reset)
        data_valid == exp_valid_d2
    ) else begin
        $display("error data_valid: expected %h, got %h",
                 $sampled(exp_valid_d2), $sampled(data_valid));
        error_count++;
    end

    data_check: assert property (
        @(posedge clk) disable iff (reset)
        exp_valid_d2 |-> data_out == exp_data_d2
    ) else begin
        $display("error data_out: expected %h, got %h",
                 $sampled(exp_data_d2), $sampled(data_out));
        error_count++;
    end

    // Flags are compared every cycle, so holding is checked too
    carry_check: assert property (
        @(posedge clk) disable iff (reset)
        carry == exp_carry_d2
    ) else begin
        $display("error carry: expected %h, got %h",
                 $sampled(exp_carry_d2), $sampled(carry));
        error_count++;
    end

    overflow_check: assert property (
        @(posedge clk) disable iff (reset)
        overflow == exp_ovf_d2
    ) else begin
        $display("error overflow: expected %h, got %h",
                 $sampled(exp_ovf_d2), $sampled(overflow));
        error_count++;
    end

    ////////////////////////////////////////////////////////////
    // Reference model and stimulus
    ////////////////////////////////////////////////////////////

    // Overflow as a true signed result outside the representable range
    task automatic model_arith(input ALUOp o, input logic [DATA_WIDTH-1:0] a,
                               input logic [DATA_WIDTH-1:0] b,
                               output logic [DATA_WIDTH-1:0] res,
                               output logic c, output logic v);
        int unsigned ua;
        int unsigned ub;
        int sa;
        int sb;
        int sres;
        ua = a;
        ub = b;
        sa = $signed(a);
        sb = $signed(b);
        if (o == ADD) begin
            res = a + b;
            c = (ua + ub) >= (1 << DATA_WIDTH);
            sres = sa + sb;
        end else begin
            res = a - b;
            c = ua >= ub;
            sres = sa - sb;
        end
        v = (sres > SIGNED_MAX) || (sres < SIGNED_MIN);
    endtask

    function automatic logic [ADDR_WIDTH-1:0] rand_addr();
        return ADDR_WIDTH'($urandom);
    endfunction

    function automatic logic [DATA_WIDTH-1:0] rand_byte();
        return DATA_WIDTH'($urandom);
    endfunction

    task automatic issue(input ALUOp o, input logic [ADDR_WIDTH-1:0] a,
                         input logic [ADDR_WIDTH-1:0] b, input logic [ADDR_WIDTH-1:0] r,
                         input logic [DATA_WIDTH-1:0] din);
        logic [DATA_WIDTH-1:0] res;
        logic c;
        logic v;
        @(posedge clk);
        cmd_valid <= 1'b1;
        op        <= o;
        addr_a    <= a;
        addr_b    <= b;
        addr_r    <= r;
        data_in   <= din;
        exp_valid <= (o != REG_WRITE);
        case (o)
            REG_READ: begin
                exp_data <= model_regs[a];
            end
            REG_WRITE: begin
                model_regs[a] = din;
            end
            default: begin
                model_arith(o, model_regs[a], model_regs[b], res, c, v);
                model_regs[r] = res;
                model_carry = c;
                model_ovf = v;
                exp_data <= res;
            end
        endcase
        exp_carry <= model_carry;
        exp_ovf   <= model_ovf;
    endtask

    // Payload toggles while idle and must be ignored
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
            data_in   <= rand_byte();
            exp_valid <= 1'b0;
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
        test_index++;
    endtask

    // Four idle edges let the last response reach its check
    task automatic finish_test(input string name);
        idle(4);
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", test_index, name);
            tests_ok++;
        end else begin
            $display("test %0d %s: %0d errors", test_index, name,
                     error_count - errors_at_start);
            tests_bad++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [ADDR_WIDTH-1:0] dest;
        ALUOp                  arith;
        void'($urandom(32'h611011b5));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        op        = REG_READ;
        addr_a    = '0;
        addr_b    = '0;
        addr_r    = '0;
        data_in   = '0;
        model_carry = 1'b0;
        model_ovf   = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        start_test();
        for (int i = 0; i < NUM_REGS; i++) begin
            issue(REG_READ, i, '0, '0, '0);
        end
        finish_test("reset state");

        start_test();
        for (int i = 0; i < NUM_REGS; i++) begin
            issue(REG_WRITE, i, '0, '0, rand_byte());
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            issue(REG_READ, i, '0, '0, rand_byte());
        end
        finish_test("write and read back");

        start_test();
        for (int i = 0; i < ADD_COUNT; i++) begin
            issue(ADD, rand_addr(), rand_addr(), rand_addr(), rand_byte());
        end
        finish_test("addition");

        start_test();
        for (int i = 0; i < SUB_COUNT; i++) begin
            dest = rand_addr();
            // Every fourth one subtracts a register from itself
            if (i % 4 == 0) begin
                issue(SUB, dest, dest, rand_addr(), rand_byte());
            end else begin
                issue(SUB, dest, rand_addr(), rand_addr(), rand_byte());
            end
        end
        finish_test("subtraction");

        start_test();
        dest = rand_addr();
        issue(REG_WRITE, dest, '0, '0, rand_byte());
        for (int i = 0; i < CHAIN_COUNT; i++) begin
            if (i % 5 == 4) begin
                dest = rand_addr();
                issue(REG_WRITE, dest, '0, '0, rand_byte());
            end else begin
                arith = ($urandom % 2 == 0) ? ADD : SUB;
                addr_r_pick: begin
                    logic [ADDR_WIDTH-1:0] next_dest;
                    next_dest = rand_addr();
                    issue(arith, dest, rand_addr(), next_dest, rand_byte());
                    dest = next_dest;
                end
            end
        end
        finish_test("back-to-back dependencies");

        start_test();
        for (int i = 0; i < HOLD_COUNT; i++) begin
            arith = ($urandom % 2 == 0) ? ADD : SUB;
            issue(arith, rand_addr(), rand_addr(), rand_addr(), rand_byte());
            issue(REG_READ, rand_addr(), '0, '0, rand_byte());
            issue(REG_WRITE, rand_addr(), '0, '0, rand_byte());
            issue(REG_READ, rand_addr(), '0, '0, rand_byte());
        end
        finish_test("flag holding");

        $display("summary: %0d tests ok, %0d with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
